/* common/xm23_bus_pkg.sv */
// XM-23 datapath encodings
`default_nettype none

package xm23_bus_pkg;

	// Field widths
	localparam int INST_W     = 7;	// Instruction type code
	localparam int BUS_CTRL_W = 7;	// Data and address bus controls
	localparam int PSW_CTRL_W = 2;	// PSW bus control and PSW/entry select
	localparam int REG_SEL_W  = 5;	// Register file select
	localparam int PRI_W      = 3;	// CPU priority
	localparam int PIC_W      = 8;	// Pending bit, priority, vector number

	// Instruction types driven into the execute stage
	localparam logic [INST_W-1:0] INST_LDW  = 7'd32;	// LD.W
	localparam logic [INST_W-1:0] INST_STW  = 7'd33;	// ST.W
	localparam logic [INST_W-1:0] INST_MOVW = 7'd21;	// MOV.W
	localparam logic [INST_W-1:0] INST_NONE = 7'd50;	// Invalid, no datapath action

	// Bus controls
	localparam logic [BUS_CTRL_W-1:0] BUS_IDLE        = '1;		// Bus not driven by the unit
	localparam logic [BUS_CTRL_W-1:0] DBUS_MDR_TO_REG = 7'd1;	// MDR into register file
	localparam logic [BUS_CTRL_W-1:0] DBUS_REG_TO_MDR = 7'd8;	// Register into MDR
	localparam logic [BUS_CTRL_W-1:0] DBUS_SRC_TO_DST = 7'd9;	// Register to register move
	localparam logic [BUS_CTRL_W-1:0] DBUS_PSW_TO_MDR = 7'd32;	// PSW into MDR
	localparam logic [BUS_CTRL_W-1:0] DBUS_CEX_TO_MDR = 7'd40;	// CEX state into MDR
	localparam logic [BUS_CTRL_W-1:0] DBUS_NONE       = 7'd63;	// No data transfer
	localparam logic [BUS_CTRL_W-1:0] ABUS_SP_TO_MAR  = 7'd8;	// SP drives MAR
	localparam logic [BUS_CTRL_W-1:0] ABUS_VECTOR     = 7'd32;	// Vector table address to MAR

	// PSW bus and vector word select
	localparam logic [PSW_CTRL_W-1:0] PSWBUS_IDLE      = 2'd3;	// PSW holds its value
	localparam logic [PSW_CTRL_W-1:0] PSWBUS_FROM_MDR  = 2'd1;	// PSW pulled from stack
	localparam logic [PSW_CTRL_W-1:0] PSWBUS_FROM_TEMP = 2'd2;	// Vector PSW from temp reg
	localparam logic [PSW_CTRL_W-1:0] VEC_SEL_PSW      = 2'd0;	// First word of the vector
	localparam logic [PSW_CTRL_W-1:0] VEC_SEL_ENTRY    = 2'd2;	// Handler entry point

	// Register numbers
	localparam logic [REG_SEL_W-1:0] REG_LR     = 5'd5;
	localparam logic [REG_SEL_W-1:0] REG_SP     = 5'd6;
	localparam logic [REG_SEL_W-1:0] REG_PC     = 5'd7;
	localparam logic [REG_SEL_W-1:0] REG_MINUS1 = 5'd15;	// Constant #FFFF
	localparam logic [REG_SEL_W-1:0] REG_TEMP   = 5'd16;	// Scratch for the vector PSW

endpackage

`default_nettype wire

/* common/iv_routine_pkg.sv */
// Interrupt routine kinds
`default_nettype none

package iv_routine_pkg;

	localparam int ROUTINE_W = 2;	// Routine kind width

	// Routine being started or run
	localparam logic [ROUTINE_W-1:0] RT_IDLE    = 2'd0;	// No routine
	localparam logic [ROUTINE_W-1:0] RT_ENTRY   = 2'd1;	// Vector entry, also trap entry
	localparam logic [ROUTINE_W-1:0] RT_RESTORE = 2'd2;	// Plain return from handler
	localparam logic [ROUTINE_W-1:0] RT_CHAIN   = 2'd3;	// Return straight into pending vector

	// Active cycles of each routine
	localparam int ENTRY_STEPS   = 9;	// Full entry
	localparam int FAULT_STEPS   = 2;	// Trap cut short by a priority fault
	localparam int RESTORE_STEPS = 5;	// Pull CEX, PSW, clear SLP, pull LR, PC
	localparam int CHAIN_STEPS   = 4;	// Record pri, vector PSW, install, entry

endpackage

`default_nettype wire

/* hdl/iv_request_decode.sv */
// Interrupt request decode
`timescale 1ns/1ps
`default_nettype none

module iv_request_decode
	import xm23_bus_pkg::*;
	import iv_routine_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 iv_enter,		// Level, entry request
	input  logic                 iv_return,		// Level, return request
	input  logic                 svc_inst,		// Entry caused by a trap
	input  logic [ROUTINE_W-1:0] routine,		// Routine now running
	input  logic                 last_step,
	input  logic [PRI_W-1:0]     curr_pri,
	input  logic [PRI_W-1:0]     new_curr_pri,	// Priority of the vector PSW
	input  logic [PRI_W-1:0]     prev_pri,		// Priority saved at entry
	input  logic [PIC_W-1:0]     pic_in,
	output logic [ROUTINE_W-1:0] req_kind,
	output logic                 trap_active,
	output logic                 pri_fault
);

	logic             pic_pending;
	logic [PRI_W-1:0] pic_pri;
	logic             chain_ok;
	logic             entry_start;
	logic             entry_end;

	assign pic_pending = pic_in[PIC_W-1];				// Top bit flags a pending vector
	assign pic_pri     = pic_in[PIC_W-2 -: PRI_W];		// Priority right below it
	assign chain_ok    = pic_pending && (pic_pri < prev_pri);

	// Entry wins over return
	always_comb begin
		if (iv_enter)
			req_kind = RT_ENTRY;
		else if (iv_return)
			req_kind = chain_ok ? RT_CHAIN : RT_RESTORE;
		else
			req_kind = RT_IDLE;
	end

	assign entry_start = (routine == RT_IDLE) && (req_kind == RT_ENTRY);	// Same edge the sequencer latches
	assign entry_end   = (routine == RT_ENTRY) && last_step;

	// Trap flag lives for the whole entry, including a faulted one
	always_ff @(posedge clk) begin
		if (rst)
			trap_active <= 1'b0;
		else if (entry_start)
			trap_active <= svc_inst;
		else if (entry_end)
			trap_active <= 1'b0;
	end

	// Trap may not lower the CPU priority
	assign pri_fault = trap_active && (new_curr_pri < curr_pri);

endmodule

`default_nettype wire

/* hdl/iv_step_sequencer.sv */
// Routine step sequencer
`timescale 1ns/1ps
`default_nettype none

module iv_step_sequencer
	import iv_routine_pkg::*;
#(
	parameter int STEP_W = 4	// Must hold ENTRY_STEPS
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [ROUTINE_W-1:0] req_kind,	// Routine asked for, RT_IDLE if none
	input  logic                 last_step,	// Current step ends the routine
	output logic [STEP_W-1:0]    step,		// 0 while idle, 1..n while active
	output logic [ROUTINE_W-1:0] routine
);

	logic idle;
	logic start;

	assign idle  = (routine == RT_IDLE);
	assign start = idle && (req_kind != RT_IDLE);	// Request only sampled here

	// Step counter
	always_ff @(posedge clk) begin
		if (rst) begin
			step <= '0;
		end else if (start) begin
			step <= STEP_W'(1);		// First step on the next cycle
		end else if (!idle) begin
			if (last_step)
				step <= '0;			// Forced idle cycle after every routine
			else
				step <= step + STEP_W'(1);
		end
	end

	// Active routine register
	always_ff @(posedge clk) begin
		if (rst) begin
			routine <= RT_IDLE;
		end else if (start) begin
			routine <= req_kind;	// Held until the last step
		end else if (!idle && last_step) begin
			routine <= RT_IDLE;
		end
	end

endmodule

`default_nettype wire

/* hdl/iv_microop_table.sv */
// Micro-operation control table
`timescale 1ns/1ps
`default_nettype none

module iv_microop_table
	import xm23_bus_pkg::*;
	import iv_routine_pkg::*;
#(
	parameter int STEP_W = 4
) (
	input  logic [STEP_W-1:0]     step,
	input  logic [ROUTINE_W-1:0]  routine,
	input  logic                  pri_fault,
	output logic                  operands,			// Operands come from this unit
	output logic                  inc_iv,			// Pre-increment SP
	output logic                  dec_iv,			// Post-decrement SP
	output logic                  iv_cpu_rst,		// CPU cycle restarts at execute
	output logic                  psw_entry_update,	// Stored priority into new PSW
	output logic                  clear_cex,
	output logic                  load_cex,
	output logic                  clr_slp_bit,
	output logic                  rec_pre_pri,		// Record current priority
	output logic                  call_pri_flt,
	output logic                  use_pic_vect,		// Vector number from PIC
	output logic                  last_step,
	output logic [INST_W-1:0]     inst_type,
	output logic [BUS_CTRL_W-1:0] data_bus_ctrl_iv,
	output logic [BUS_CTRL_W-1:0] addr_bus_ctrl_iv,
	output logic [PSW_CTRL_W-1:0] psw_bus_ctrl_iv,
	output logic [PSW_CTRL_W-1:0] psw_ent,			// PSW or entry word of the vector
	output logic [REG_SEL_W-1:0]  data_src_iv,
	output logic [REG_SEL_W-1:0]  addr_src_iv,
	output logic [REG_SEL_W-1:0]  data_dst_iv
);

	always_comb begin
		// Idle values, also the base of every step
		operands         = 1'b0;
		inc_iv           = 1'b0;
		dec_iv           = 1'b0;
		iv_cpu_rst       = 1'b0;
		psw_entry_update = 1'b0;
		clear_cex        = 1'b0;
		load_cex         = 1'b0;
		clr_slp_bit      = 1'b0;
		rec_pre_pri      = 1'b0;
		call_pri_flt     = 1'b0;
		use_pic_vect     = 1'b0;
		last_step        = 1'b0;
		inst_type        = INST_NONE;
		data_bus_ctrl_iv = BUS_IDLE;
		addr_bus_ctrl_iv = BUS_IDLE;
		psw_bus_ctrl_iv  = PSWBUS_IDLE;
		psw_ent          = VEC_SEL_PSW;
		data_src_iv      = '0;
		addr_src_iv      = '0;
		data_dst_iv      = '0;

		case (routine)
			RT_ENTRY: begin
				operands   = 1'b1;
				iv_cpu_rst = 1'b1;
				last_step  = (step == STEP_W'(ENTRY_STEPS)) ||
					(pri_fault && (step == STEP_W'(FAULT_STEPS)));	// Fault ends entry early
				case (step)
					1: begin							// Vector PSW into temp
						inst_type        = INST_LDW;
						data_bus_ctrl_iv = DBUS_MDR_TO_REG;
						addr_bus_ctrl_iv = ABUS_VECTOR;
						psw_ent          = VEC_SEL_PSW;
						data_dst_iv      = REG_TEMP;
					end
					2, 3, 4, 5: begin					// Stack pushes, SP post-decrement
						inst_type        = INST_STW;
						dec_iv           = 1'b1;
						data_bus_ctrl_iv = DBUS_REG_TO_MDR;
						addr_bus_ctrl_iv = ABUS_SP_TO_MAR;
						addr_src_iv      = REG_SP;
						data_dst_iv      = REG_SP;		// Decremented SP written back
						case (step)
							2: data_src_iv = REG_PC;
							3: data_src_iv = REG_LR;
							4: data_bus_ctrl_iv = DBUS_PSW_TO_MDR;
							default: begin
								data_bus_ctrl_iv = DBUS_CEX_TO_MDR;
								rec_pre_pri      = 1'b1;	// Priority saved before new PSW
							end
						endcase
						if (pri_fault && step == 2) begin
							// Nothing pushed, the fault handler takes over
							inst_type        = INST_NONE;
							dec_iv           = 1'b0;
							call_pri_flt     = 1'b1;
							data_bus_ctrl_iv = BUS_IDLE;
							addr_bus_ctrl_iv = BUS_IDLE;
							data_src_iv      = '0;
							addr_src_iv      = '0;
							data_dst_iv      = '0;
						end
					end
					6: begin							// Install vector PSW
						psw_bus_ctrl_iv = PSWBUS_FROM_TEMP;
						data_src_iv     = REG_TEMP;
					end
					7: begin							// Handler entry point into PC
						inst_type        = INST_LDW;
						psw_entry_update = 1'b1;
						clr_slp_bit      = 1'b1;
						data_bus_ctrl_iv = DBUS_MDR_TO_REG;
						addr_bus_ctrl_iv = ABUS_VECTOR;
						psw_ent          = VEC_SEL_ENTRY;
						data_dst_iv      = REG_PC;
					end
					8: begin							// LR = #FFFF marks a handler return
						inst_type        = INST_MOVW;
						data_bus_ctrl_iv = DBUS_SRC_TO_DST;
						data_src_iv      = REG_MINUS1;
						data_dst_iv      = REG_LR;
					end
					9: begin
						clear_cex  = 1'b1;
						iv_cpu_rst = 1'b0;				// CPU resumes at fetch
					end
					default: ;
				endcase
			end

			RT_RESTORE: begin
				operands   = 1'b1;
				iv_cpu_rst = 1'b1;
				inc_iv     = 1'b1;						// Every pull pre-increments SP
				last_step  = (step == STEP_W'(RESTORE_STEPS));
				case (step)
					1, 2: begin							// CEX then PSW from stack
						inst_type        = INST_LDW;
						data_bus_ctrl_iv = DBUS_NONE;
						addr_bus_ctrl_iv = ABUS_SP_TO_MAR;
						addr_src_iv      = REG_SP;
						data_dst_iv      = REG_SP;
						if (step == 1) begin
							load_cex    = 1'b1;
							data_src_iv = REG_SP;
						end else begin
							psw_bus_ctrl_iv = PSWBUS_FROM_MDR;
						end
					end
					3: clr_slp_bit = 1'b1;
					4, 5: begin							// LR then PC from stack
						inst_type        = INST_LDW;
						data_bus_ctrl_iv = DBUS_MDR_TO_REG;
						addr_bus_ctrl_iv = ABUS_SP_TO_MAR;
						addr_src_iv      = REG_SP;
						data_src_iv      = REG_SP;
						data_dst_iv      = (step == 4) ? REG_LR : REG_PC;
					end
					default: ;
				endcase
			end

			RT_CHAIN: begin
				operands   = 1'b1;
				iv_cpu_rst = 1'b1;
				last_step  = (step == STEP_W'(CHAIN_STEPS));
				case (step)
					1: begin
						operands    = 1'b0;				// Only the priority is recorded
						rec_pre_pri = 1'b1;
					end
					2: begin							// Pending vector PSW into temp
						inst_type        = INST_LDW;
						use_pic_vect     = 1'b1;
						data_bus_ctrl_iv = DBUS_MDR_TO_REG;
						addr_bus_ctrl_iv = ABUS_VECTOR;
						psw_ent          = VEC_SEL_PSW;
						data_dst_iv      = REG_TEMP;
					end
					3: begin
						psw_bus_ctrl_iv  = PSWBUS_FROM_TEMP;
						data_src_iv      = REG_TEMP;
						psw_entry_update = 1'b1;
						clr_slp_bit      = 1'b1;
					end
					4: begin
						inst_type        = INST_LDW;
						data_bus_ctrl_iv = DBUS_MDR_TO_REG;
						addr_bus_ctrl_iv = ABUS_VECTOR;
						psw_ent          = VEC_SEL_ENTRY;
						data_dst_iv      = REG_PC;
					end
					default: ;
				endcase
			end

			default: ;									// Idle keeps the defaults
		endcase
	end

endmodule

`default_nettype wire

/* hdl/iv_vect_unit.sv */
// XM-23 interrupt vector sequencer
`timescale 1ns/1ps
`default_nettype none

module iv_vect_unit
	import xm23_bus_pkg::*;
	import iv_routine_pkg::*;
#(
	parameter int STEP_W = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  iv_enter,
	input  logic                  iv_return,
	input  logic                  svc_inst,
	input  logic [PRI_W-1:0]      curr_pri,
	input  logic [PRI_W-1:0]      new_curr_pri,
	input  logic [PRI_W-1:0]      prev_pri,
	input  logic [PIC_W-1:0]      pic_in,
	output logic                  operands,
	output logic                  inc_iv,
	output logic                  dec_iv,
	output logic                  iv_cpu_rst,
	output logic                  psw_entry_update,
	output logic                  clear_cex,
	output logic                  load_cex,
	output logic                  clr_slp_bit,
	output logic                  rec_pre_pri,
	output logic                  call_pri_flt,
	output logic                  use_pic_vect,
	output logic                  iv_done,			// High during the last step
	output logic                  result,			// Trap in progress
	output logic [INST_W-1:0]     inst_type,
	output logic [BUS_CTRL_W-1:0] data_bus_ctrl_iv,
	output logic [BUS_CTRL_W-1:0] addr_bus_ctrl_iv,
	output logic [PSW_CTRL_W-1:0] psw_bus_ctrl_iv,
	output logic [PSW_CTRL_W-1:0] psw_ent,
	output logic [REG_SEL_W-1:0]  data_src_iv,
	output logic [REG_SEL_W-1:0]  addr_src_iv,
	output logic [REG_SEL_W-1:0]  data_dst_iv
);

	logic [ROUTINE_W-1:0] req_kind;
	logic [ROUTINE_W-1:0] routine;
	logic [STEP_W-1:0]    step;
	logic                 trap_active;
	logic                 pri_fault;

	assign result = trap_active;

	iv_request_decode u_decode (
		.clk(clk), .rst(rst), .iv_enter(iv_enter), .iv_return(iv_return),
		.svc_inst(svc_inst), .routine(routine), .last_step(iv_done),
		.curr_pri(curr_pri), .new_curr_pri(new_curr_pri), .prev_pri(prev_pri),
		.pic_in(pic_in), .req_kind(req_kind), .trap_active(trap_active),
		.pri_fault(pri_fault)
	);

	iv_step_sequencer #(.STEP_W(STEP_W)) u_seq (
		.clk(clk), .rst(rst), .req_kind(req_kind), .last_step(iv_done),
		.step(step), .routine(routine)
	);

	iv_microop_table #(.STEP_W(STEP_W)) u_table (
		.step(step), .routine(routine), .pri_fault(pri_fault),
		.operands(operands), .inc_iv(inc_iv), .dec_iv(dec_iv), .iv_cpu_rst(iv_cpu_rst),
		.psw_entry_update(psw_entry_update), .clear_cex(clear_cex), .load_cex(load_cex),
		.clr_slp_bit(clr_slp_bit), .rec_pre_pri(rec_pre_pri), .call_pri_flt(call_pri_flt),
		.use_pic_vect(use_pic_vect), .last_step(iv_done), .inst_type(inst_type),
		.data_bus_ctrl_iv(data_bus_ctrl_iv), .addr_bus_ctrl_iv(addr_bus_ctrl_iv),
		.psw_bus_ctrl_iv(psw_bus_ctrl_iv), .psw_ent(psw_ent), .data_src_iv(data_src_iv),
		.addr_src_iv(addr_src_iv), .data_dst_iv(data_dst_iv)
	);

endmodule

`default_nettype wire

/* verification/iv_vect_unit_asserts.sv */
// Sequencer output assertions
`timescale 1ns/1ps
`default_nettype none

module iv_vect_unit_asserts (
	input wire logic clk,
	input wire logic rst,
	input wire logic dec_iv,
	input wire logic inc_iv,
	input wire logic iv_done,
	input wire logic operands,
	input wire logic call_pri_flt
);

	// SP moves one way per step
	assert property (@(posedge clk) disable iff (rst) !(dec_iv && inc_iv))
		else $error("dec_iv and inc_iv high together");

	// Forced idle cycle after every routine
	assert property (@(posedge clk) disable iff (rst) iv_done |=> (!operands && !iv_done))
		else $error("no idle cycle after iv_done");

	assert property (@(posedge clk) disable iff (rst) call_pri_flt |-> iv_done)
		else $error("call_pri_flt without iv_done");	// Fault always ends the entry

endmodule

bind iv_vect_unit iv_vect_unit_asserts u_asserts (
	.clk(clk), .rst(rst), .dec_iv(dec_iv), .inc_iv(inc_iv), .iv_done(iv_done),
	.operands(operands), .call_pri_flt(call_pri_flt)
);

`default_nettype wire

/* verification/iv_vect_unit_tb.sv */
// Interrupt vector unit testbench
`timescale 1ns/1ps
`default_nettype none

module iv_vect_unit_tb
	import xm23_bus_pkg::*;
	import iv_routine_pkg::*;
();

	localparam int N_ROWS       = 6;
	localparam int STEP_TIMEOUT = 20;	// Cycles allowed for one routine

	logic clk, rst, iv_enter, iv_return, svc_inst;
	logic [PRI_W-1:0] curr_pri, new_curr_pri, prev_pri;
	logic [PIC_W-1:0] pic_in;
	logic operands, inc_iv, dec_iv, iv_cpu_rst, psw_entry_update, clear_cex, load_cex;
	logic clr_slp_bit, rec_pre_pri, call_pri_flt, use_pic_vect, iv_done, result;
	logic [INST_W-1:0]     inst_type;
	logic [BUS_CTRL_W-1:0] data_bus_ctrl_iv, addr_bus_ctrl_iv;
	logic [PSW_CTRL_W-1:0] psw_bus_ctrl_iv, psw_ent;
	logic [REG_SEL_W-1:0]  data_src_iv, addr_src_iv, data_dst_iv;

	// Scenario table
	string                row_name [N_ROWS];
	logic [ROUTINE_W-1:0] row_kind [N_ROWS];	// Routine expected to run
	logic                 row_svc [N_ROWS];
	logic [PRI_W-1:0]     row_curr [N_ROWS], row_new [N_ROWS], row_prev [N_ROWS];
	logic [PIC_W-1:0]     row_pic [N_ROWS];
	int                   row_cycles [N_ROWS];
	string                row_seq [N_ROWS];		// inst_type per step, one letter each

	integer seed;
	int     err_count, pass_count;

	iv_vect_unit #(.STEP_W(4)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;		// 100 ns period
	end

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0b got %0b", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_inst(input string name, input logic [INST_W-1:0] exp,
			input logic [INST_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_bus(input string name, input logic [BUS_CTRL_W-1:0] exp,
			input logic [BUS_CTRL_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_SEL_W-1:0] exp,
			input logic [REG_SEL_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_psw(input string name, input logic [PSW_CTRL_W-1:0] exp,
			input logic [PSW_CTRL_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			err_count++;
		end
	endtask

	// L = LD.W, S = ST.W, M = MOV.W, N = none
	function automatic logic [INST_W-1:0] inst_code(input byte c);
		case (c)
			"L": return INST_LDW;
			"S": return INST_STW;
			"M": return INST_MOVW;
			default: return INST_NONE;
		endcase
	endfunction

	task automatic load_table();
		row_name = '{"plain entry", "trap", "trap with fault", "restore",
			"restore, pending too low", "chained return"};
		row_kind = '{RT_ENTRY, RT_ENTRY, RT_ENTRY, RT_RESTORE, RT_RESTORE, RT_CHAIN};
		row_svc    = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
		row_curr   = '{3'd0, 3'd3, 3'd5, 3'd0, 3'd4, 3'd4};
		row_new    = '{3'd0, 3'd5, 3'd2, 3'd0, 3'd4, 3'd4};
		row_prev   = '{3'd0, 3'd6, 3'd6, 3'd0, 3'd2, 3'd5};
		row_pic    = '{8'h00, 8'h00, 8'h00, 8'h35, 8'hD3, 8'hA7};	// Bit 7 pending, 6:4 pri
		row_cycles = '{ENTRY_STEPS, ENTRY_STEPS, FAULT_STEPS, RESTORE_STEPS,
			RESTORE_STEPS, CHAIN_STEPS};
		row_seq = '{"LSSSSNLMN", "LSSSSNLMN", "LN", "LLNLL", "LLNLL", "NLNL"};
		foreach (row_curr[r]) begin
			if (r == 0 || r == 3) begin	// Priorities do not matter here
				row_curr[r] = $random(seed);
				row_new[r]  = $random(seed);
				row_prev[r] = $random(seed);
			end
		end
	endtask

	task automatic expect_idle();
		check_bit("operands", 1'b0, operands);
		check_bit("inc_iv", 1'b0, inc_iv);
		check_bit("dec_iv", 1'b0, dec_iv);
		check_bit("iv_cpu_rst", 1'b0, iv_cpu_rst);
		check_bit("psw_entry_update", 1'b0, psw_entry_update);
		check_bit("clear_cex", 1'b0, clear_cex);
		check_bit("load_cex", 1'b0, load_cex);
		check_bit("clr_slp_bit", 1'b0, clr_slp_bit);
		check_bit("rec_pre_pri", 1'b0, rec_pre_pri);
		check_bit("call_pri_flt", 1'b0, call_pri_flt);
		check_bit("use_pic_vect", 1'b0, use_pic_vect);
		check_bit("iv_done", 1'b0, iv_done);
		check_bit("result", 1'b0, result);
		check_inst("inst_type", INST_NONE, inst_type);
		check_bus("data_bus_ctrl_iv", BUS_IDLE, data_bus_ctrl_iv);
		check_bus("addr_bus_ctrl_iv", BUS_IDLE, addr_bus_ctrl_iv);
		check_psw("psw_bus_ctrl_iv", PSWBUS_IDLE, psw_bus_ctrl_iv);
	endtask

	// Controls of step n of row r
	task automatic step_controls(input int r, input logic fault, input int n);
		string            seq;
		logic [ROUTINE_W-1:0] k;
		seq = row_seq[r];
		k   = row_kind[r];
		check_inst("inst_type", (n <= seq.len()) ? inst_code(seq[n-1]) : INST_NONE, inst_type);
		check_bit("iv_done", n == row_cycles[r], iv_done);
		check_bit("result", k == RT_ENTRY && row_svc[r], result);	// Trap flag over whole entry
		check_bit("operands", !(k == RT_CHAIN && n == 1), operands);
		check_bit("iv_cpu_rst", !(k == RT_ENTRY && n == 9), iv_cpu_rst);	// Fetch resumes last
		check_bit("inc_iv", k == RT_RESTORE, inc_iv);
		check_bit("dec_iv", k == RT_ENTRY && !fault && n >= 2 && n <= 5, dec_iv);
		check_bit("call_pri_flt", k == RT_ENTRY && fault && n == 2, call_pri_flt);
		check_bit("clear_cex", k == RT_ENTRY && n == 9, clear_cex);
		check_bit("load_cex", k == RT_RESTORE && n == 1, load_cex);
		check_bit("use_pic_vect", k == RT_CHAIN && n == 2, use_pic_vect);
		check_bit("rec_pre_pri", (k == RT_ENTRY && n == 5) || (k == RT_CHAIN && n == 1),
			rec_pre_pri);
		check_bit("clr_slp_bit", (k == RT_ENTRY && n == 7) || (k != RT_ENTRY && n == 3),
			clr_slp_bit);
		check_bit("psw_entry_update", (k == RT_ENTRY && n == 7) || (k == RT_CHAIN && n == 3),
			psw_entry_update);
		if (k == RT_ENTRY && n == 1)
			check_reg("data_dst_iv", REG_TEMP, data_dst_iv);	// Vector PSW into temp
		if (k == RT_ENTRY && fault && n == 2)
			check_bus("data_bus_ctrl_iv", BUS_IDLE, data_bus_ctrl_iv);	// No push
		if ((k == RT_ENTRY && !fault && n >= 2 && n <= 5) ||
				(k == RT_RESTORE && n != 3)) begin
			check_bus("addr_bus_ctrl_iv", ABUS_SP_TO_MAR, addr_bus_ctrl_iv);	// Stack access
			check_reg("addr_src_iv", REG_SP, addr_src_iv);
		end
		if (k == RT_ENTRY && n == 6)
			check_psw("psw_bus_ctrl_iv", PSWBUS_FROM_TEMP, psw_bus_ctrl_iv);
		if (k == RT_ENTRY && n == 8)
			check_reg("data_src_iv", REG_MINUS1, data_src_iv);
		if (k == RT_RESTORE && n == 2)
			check_psw("psw_bus_ctrl_iv", PSWBUS_FROM_MDR, psw_bus_ctrl_iv);
		if (k == RT_RESTORE && n == 5)
			check_reg("data_dst_iv", REG_PC, data_dst_iv);
		if (k == RT_CHAIN && n == 4)
			check_psw("psw_ent", VEC_SEL_ENTRY, psw_ent);
	endtask

	task automatic run_row(input int r);
		int   n;
		int   errs_before;
		logic fault;
		logic done;
		errs_before = err_count;
		fault = row_svc[r] && (row_new[r] < row_curr[r]);
		@(posedge clk);
		#5;
		iv_enter     = (row_kind[r] == RT_ENTRY);
		iv_return    = (row_kind[r] != RT_ENTRY);
		svc_inst     = row_svc[r];
		curr_pri     = row_curr[r];
		new_curr_pri = row_new[r];
		prev_pri     = row_prev[r];
		pic_in       = row_pic[r];
		@(posedge clk);		// Start edge
		#5;
		iv_enter  = 1'b0;
		iv_return = 1'b0;
		svc_inst  = 1'b0;	// Already latched at start
		n    = 0;
		done = 1'b0;
		while (!done && n < STEP_TIMEOUT) begin
			@(negedge clk);
			n++;
			step_controls(r, fault, n);
			done = iv_done;
		end
		if (!done) begin
			$display("ERROR at %0t: scenario %0d, iv_done never rose", $time, r);
			err_count++;
		end else if (n != row_cycles[r]) begin
			$display("CHECK FAILED at %0t: active_cycles expected %0d got %0d",
				$time, row_cycles[r], n);
			err_count++;
		end
		@(negedge clk);
		expect_idle();		// Idle cycle after the routine
		if (err_count == errs_before) begin
			pass_count++;
			$display("scenario %0d, %s: ok", r, row_name[r]);
		end else begin
			$display("scenario %0d, %s: %0d errors", r, row_name[r], err_count - errs_before);
		end
	endtask

	initial begin
		seed         = 72;
		err_count    = 0;
		pass_count   = 0;
		rst          = 1'b1;
		iv_enter     = 1'b0;
		iv_return    = 1'b0;
		svc_inst     = 1'b0;
		curr_pri     = '0;
		new_curr_pri = '0;
		prev_pri     = '0;
		pic_in       = '0;
		load_table();
		repeat (10) @(posedge clk);
		#5 rst = 1'b0;
		@(negedge clk);
		expect_idle();
		if (err_count == 0)
			pass_count++;
		$display("reset and idle: %0d errors", err_count);
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		$display("%0d of %0d tests ok, %0d errors", pass_count, N_ROWS + 1, err_count);
		if (err_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* xm23_iv.f */
common/xm23_bus_pkg.sv
common/iv_routine_pkg.sv
hdl/iv_request_decode.sv
hdl/iv_step_sequencer.sv
hdl/iv_microop_table.sv
hdl/iv_vect_unit.sv
verification/iv_vect_unit_asserts.sv
verification/iv_vect_unit_tb.sv
